/* hw/commandDecoder.sv */
module commandDecoder
	import gamePkg::*;
(
	input logic clk,
	input logic reset,
	input byteT rxData,
	input logic rxValid,
	output logic cmdValid,
	output opcodeT cmdOpcode,
	output logic [4:0] cmdOperand,
	output logic cmdInvalid
);

	opcodeT rxOpcode;
	logic opcodeKnown;

	assign rxOpcode = rxData[7:5];

	// only the five defined opcodes are accepted
	always_comb begin
		case (rxOpcode)
			opResetGame,
			opMoveAlien,
			opShoot,
			opReadScore,
			opReadRandom: opcodeKnown = 1'b1;
			default: opcodeKnown = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cmdValid <= 1'b0;
			cmdInvalid <= 1'b0;
		end else begin
			cmdValid <= rxValid;
			if (rxValid)
				cmdInvalid <= !opcodeKnown;
		end
	end

	// fields held until the next byte arrives
	always_ff @(posedge clk) begin
		if (rxValid) begin
			cmdOpcode <= rxOpcode;
			cmdOperand <= rxData[4:0];
		end
	end

endmodule

/* hw/gameEngine.sv */
module gameEngine
	import gamePkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input opcodeT cmdOpcode,
	input logic [4:0] cmdOperand,
	input logic cmdInvalid,
	output logic replyValid,
	output byteT replyData,
	output alienXT alienX,
	output alienYT alienY,
	output scoreT score,
	output logic lastHit
);

	lfsrT lfsr;
	lfsrT lfsrNext;
	scoreT scoreInc;
	logic shotHits;

	byteT nextReply;
	alienXT nextX;
	alienYT nextY;
	scoreT nextScore;
	lfsrT nextLfsr;
	logic nextHit;

	// taps 15, 13, 12, 10 feed bit 0
	assign lfsrNext = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

	assign scoreInc = score + 1'b1;
	assign shotHits = (cmdOperand[2:0] == alienX);

	always_comb begin
		nextReply = errorReply;
		nextX = alienX;
		nextY = alienY;
		nextScore = score;
		nextLfsr = lfsr;
		nextHit = lastHit;
		// invalid opcodes keep the error reply and all state
		if (!cmdInvalid) begin
			case (cmdOpcode)
				opResetGame: begin
					nextX = '0;
					nextY = '0;
					nextScore = '0;
					nextReply = ackReply;
				end
				opMoveAlien: begin
					nextY = cmdOperand[4:3];
					nextX = cmdOperand[2:0];
					nextReply = {cmdOpcode, cmdOperand};
				end
				opShoot: begin
					nextHit = shotHits;
					if (shotHits) begin
						nextScore = scoreInc;
						nextReply = hitFlag | {1'b0, scoreInc};
					end else begin
						nextReply = {1'b0, score};
					end
				end
				opReadScore: nextReply = {1'b0, score};
				opReadRandom: begin
					nextLfsr = lfsrNext;
					nextReply = lfsrNext[7:0];
				end
				default: nextReply = errorReply;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			replyValid <= 1'b0;
			alienX <= '0;
			alienY <= '0;
			score <= '0;
			lfsr <= lfsrSeed;
			lastHit <= 1'b0;
		end else begin
			replyValid <= cmdValid;
			if (cmdValid) begin
				alienX <= nextX;
				alienY <= nextY;
				score <= nextScore;
				lfsr <= nextLfsr;
				lastHit <= nextHit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmdValid)
			replyData <= nextReply;
	end

endmodule

/* hw/gamePkg.sv */
package gamePkg;

	// serial byte as seen on both wires
	typedef logic [7:0] byteT;

	// command fields
	typedef logic [2:0] opcodeT;

	// alien position on the playfield
	typedef logic [2:0] alienXT;
	typedef logic [1:0] alienYT;

	// score wraps from 127 back to 0
	typedef logic [6:0] scoreT;

	// random generator state
	typedef logic [15:0] lfsrT;

	// active low, bit 0 drives segment a
	typedef logic [6:0] segmentT;

	// opcodes in bits 7:5 of a command byte
	localparam opcodeT opResetGame = 3'd0;
	localparam opcodeT opMoveAlien = 3'd1;
	localparam opcodeT opShoot = 3'd2;
	localparam opcodeT opReadScore = 3'd3;
	localparam opcodeT opReadRandom = 3'd4;

	// LFSR value after reset
	localparam lfsrT lfsrSeed = 16'hACE1;

	// fixed replies
	localparam byteT ackReply = 8'h00;
	localparam byteT errorReply = 8'hEE;

	// set in a shoot reply when the shot hit
	localparam byteT hitFlag = 8'h80;

endpackage

/* hw/gameTop.sv */
module gameTop
	import gamePkg::*;
#(
	// 115200 baud from 50 MHz
	parameter int clksPerBit = 434
) (
	input logic clk,
	input logic reset,
	input logic serialIn,
	output logic serialOut,
	output segmentT hex0,
	output segmentT hex1,
	output segmentT hex4,
	output segmentT hex5,
	output logic [9:0] ledr
);

	byteT rxData;
	logic rxValid;

	logic cmdValid;
	opcodeT cmdOpcode;
	logic [4:0] cmdOperand;
	logic cmdInvalid;

	logic replyValid;
	byteT replyData;
	alienXT alienX;
	alienYT alienY;
	scoreT score;
	logic lastHit;

	logic txStart;
	byteT txData;
	logic busy;

	serialReceiver #(.clksPerBit(clksPerBit)) receiver0 (
		.clk(clk),
		.reset(reset),
		.serialIn(serialIn),
		.rxData(rxData),
		.rxValid(rxValid)
	);

	commandDecoder decoder0 (
		.clk(clk),
		.reset(reset),
		.rxData(rxData),
		.rxValid(rxValid),
		.cmdValid(cmdValid),
		.cmdOpcode(cmdOpcode),
		.cmdOperand(cmdOperand),
		.cmdInvalid(cmdInvalid)
	);

	gameEngine engine0 (
		.clk(clk),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmdOpcode(cmdOpcode),
		.cmdOperand(cmdOperand),
		.cmdInvalid(cmdInvalid),
		.replyValid(replyValid),
		.replyData(replyData),
		.alienX(alienX),
		.alienY(alienY),
		.score(score),
		.lastHit(lastHit)
	);

	// reply path and board display
	replyFormatter formatter0 (
		.clk(clk),
		.reset(reset),
		.replyValid(replyValid),
		.replyData(replyData),
		.alienX(alienX),
		.alienY(alienY),
		.score(score),
		.lastHit(lastHit),
		.busy(busy),
		.txStart(txStart),
		.txData(txData),
		.hex0(hex0),
		.hex1(hex1),
		.hex4(hex4),
		.hex5(hex5),
		.ledr(ledr)
	);

	serialTransmitter #(.clksPerBit(clksPerBit)) transmitter0 (
		.clk(clk),
		.reset(reset),
		.txStart(txStart),
		.txData(txData),
		.serialOut(serialOut),
		.busy(busy)
	);

endmodule

/* hw/replyFormatter.sv */
module replyFormatter
	import gamePkg::*;
(
	input logic clk,
	input logic reset,
	input logic replyValid,
	input byteT replyData,
	input alienXT alienX,
	input alienYT alienY,
	input scoreT score,
	input logic lastHit,
	input logic busy,
	output logic txStart,
	output byteT txData,
	output segmentT hex0,
	output segmentT hex1,
	output segmentT hex4,
	output segmentT hex5,
	output logic [9:0] ledr
);

	// hex digit to active-low pattern, gfedcba
	function automatic segmentT hexToSeg(input logic [3:0] digit);
		case (digit)
			4'h0: hexToSeg = 7'b1000000;
			4'h1: hexToSeg = 7'b1111001;
			4'h2: hexToSeg = 7'b0100100;
			4'h3: hexToSeg = 7'b0110000;
			4'h4: hexToSeg = 7'b0011001;
			4'h5: hexToSeg = 7'b0010010;
			4'h6: hexToSeg = 7'b0000010;
			4'h7: hexToSeg = 7'b1111000;
			4'h8: hexToSeg = 7'b0000000;
			4'h9: hexToSeg = 7'b0010000;
			4'hA: hexToSeg = 7'b0001000;
			4'hB: hexToSeg = 7'b0000011;
			4'hC: hexToSeg = 7'b1000110;
			4'hD: hexToSeg = 7'b0100001;
			4'hE: hexToSeg = 7'b0000110;
			default: hexToSeg = 7'b0001110;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			txStart <= 1'b0;
			hex0 <= hexToSeg(4'h0);
			hex1 <= hexToSeg(4'h0);
			hex4 <= hexToSeg(4'h0);
			hex5 <= hexToSeg(4'h0);
			ledr <= '0;
		end else begin
			// no back-pressure, a reply during busy is lost
			txStart <= replyValid && !busy;
			hex0 <= hexToSeg({1'b0, alienX});
			hex1 <= hexToSeg({2'b00, alienY});
			hex4 <= hexToSeg(score[3:0]);
			hex5 <= hexToSeg({1'b0, score[6:4]});
			ledr[9] <= busy;
			ledr[8] <= lastHit;
			if (replyValid)
				ledr[7:0] <= replyData;
		end
	end

	always_ff @(posedge clk) begin
		if (replyValid)
			txData <= replyData;
	end

endmodule

/* hw/serialReceiver.sv */
module serialReceiver
	import gamePkg::*;
#(
	parameter int clksPerBit = 434
) (
	input logic clk,
	input logic reset,
	input logic serialIn,
	output byteT rxData,
	output logic rxValid
);

	localparam int countWidth = $clog2(clksPerBit);

	typedef logic [countWidth-1:0] countT;

	localparam countT lastCount = countT'(clksPerBit - 1);
	localparam countT halfCount = countT'((clksPerBit - 1) / 2);

	typedef enum logic [1:0] {
		stateIdle,
		stateStart,
		stateData,
		stateStop
	} rxStateT;

	rxStateT state;
	countT clkCount;
	logic [2:0] bitIndex;
	logic serialSync1;
	logic serialSync2;

	// two-flop synchronizer, line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			serialSync1 <= 1'b1;
			serialSync2 <= 1'b1;
		end else begin
			serialSync1 <= serialIn;
			serialSync2 <= serialSync1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stateIdle;
			clkCount <= '0;
			bitIndex <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			case (state)
				stateIdle: begin
					clkCount <= '0;
					bitIndex <= '0;
					if (!serialSync2)
						state <= stateStart;
				end
				stateStart: begin
					// check start bit at its middle
					if (clkCount == halfCount) begin
						clkCount <= '0;
						state <= serialSync2 ? stateIdle : stateData;
					end else begin
						clkCount <= clkCount + 1'b1;
					end
				end
				stateData: begin
					if (clkCount == lastCount) begin
						clkCount <= '0;
						// LSB first
						rxData <= {serialSync2, rxData[7:1]};
						bitIndex <= bitIndex + 1'b1;
						if (bitIndex == 3'd7)
							state <= stateStop;
					end else begin
						clkCount <= clkCount + 1'b1;
					end
				end
				stateStop: begin
					if (clkCount == lastCount) begin
						// a low stop bit drops the byte
						rxValid <= serialSync2;
						state <= stateIdle;
					end else begin
						clkCount <= clkCount + 1'b1;
					end
				end
				default: state <= stateIdle;
			endcase
		end
	end

endmodule

/* hw/serialTransmitter.sv */
module serialTransmitter
	import gamePkg::*;
#(
	parameter int clksPerBit = 434
) (
	input logic clk,
	input logic reset,
	input logic txStart,
	input byteT txData,
	output logic serialOut,
	output logic busy
);

	localparam int countWidth = $clog2(clksPerBit);

	typedef logic [countWidth-1:0] countT;

	localparam countT lastCount = countT'(clksPerBit - 1);

	typedef enum logic [1:0] {
		stateIdle,
		stateStart,
		stateData,
		stateStop
	} txStateT;

	txStateT state;
	countT clkCount;
	logic [2:0] bitIndex;
	byteT shiftReg;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stateIdle;
			clkCount <= '0;
			bitIndex <= '0;
			serialOut <= 1'b1;
			busy <= 1'b0;
		end else begin
			if (state != stateIdle)
				clkCount <= (clkCount == lastCount) ? '0 : clkCount + 1'b1;
			case (state)
				stateIdle: begin
					clkCount <= '0;
					bitIndex <= '0;
					if (txStart) begin
						shiftReg <= txData;
						serialOut <= 1'b0;
						busy <= 1'b1;
						state <= stateStart;
					end
				end
				stateStart: begin
					if (clkCount == lastCount) begin
						serialOut <= shiftReg[0];
						state <= stateData;
					end
				end
				stateData: begin
					if (clkCount == lastCount) begin
						bitIndex <= bitIndex + 1'b1;
						shiftReg <= shiftReg >> 1;
						if (bitIndex == 3'd7) begin
							serialOut <= 1'b1;
							state <= stateStop;
						end else begin
							serialOut <= shiftReg[1];
						end
					end
				end
				stateStop: begin
					// line stays high after the frame
					if (clkCount == lastCount) begin
						busy <= 1'b0;
						state <= stateIdle;
					end
				end
				default: state <= stateIdle;
			endcase
		end
	end

endmodule

/* src.f */
+incdir+testbench
hw/gamePkg.sv
hw/serialReceiver.sv
hw/commandDecoder.sv
hw/gameEngine.sv
hw/replyFormatter.sv
hw/serialTransmitter.sv
hw/gameTop.sv
testbench/gameTb.sv

/* testbench/gameTbModel.svh */
`ifndef gameTbModelSvh
`define gameTbModelSvh

// game state as the host expects it
alienXT modelX;
alienYT modelY;
scoreT modelScore;
lfsrT modelLfsr;
logic modelHit;
byteT modelLastReply;

task automatic resetModel();
	modelX = '0;
	modelY = '0;
	modelScore = '0;
	modelLfsr = lfsrSeed;
	modelHit = 1'b0;
	modelLastReply = '0;
endtask

// shift left, bit 0 gets 15 ^ 13 ^ 12 ^ 10
function automatic lfsrT stepLfsr(input lfsrT value);
	return {value[14:0], value[15] ^ value[13] ^ value[12] ^ value[10]};
endfunction

// expected reply for one command, model state moves along
function automatic byteT predictReply(input byteT cmd);
	opcodeT op;
	logic [4:0] arg;
	byteT reply;
	op = cmd[7:5];
	arg = cmd[4:0];
	reply = errorReply;
	case (op)
		opResetGame: begin
			modelX = '0;
			modelY = '0;
			modelScore = '0;
			reply = ackReply;
		end
		opMoveAlien: begin
			modelY = arg[4:3];
			modelX = arg[2:0];
			reply = cmd;
		end
		opShoot: begin
			modelHit = (arg[2:0] == modelX);
			if (modelHit) begin
				modelScore = modelScore + 7'd1;
				reply = 8'h80 | {1'b0, modelScore};
			end else begin
				reply = {1'b0, modelScore};
			end
		end
		opReadScore: reply = {1'b0, modelScore};
		opReadRandom: begin
			modelLfsr = stepLfsr(modelLfsr);
			reply = modelLfsr[7:0];
		end
		default: reply = errorReply;
	endcase
	return reply;
endfunction

// lit segments first (gfedcba), then inverted for the active-low pins
function automatic segmentT segmentFor(input logic [3:0] digit);
	logic [6:0] lit;
	case (digit)
		4'h0: lit = 7'h3F;
		4'h1: lit = 7'h06;
		4'h2: lit = 7'h5B;
		4'h3: lit = 7'h4F;
		4'h4: lit = 7'h66;
		4'h5: lit = 7'h6D;
		4'h6: lit = 7'h7D;
		4'h7: lit = 7'h07;
		4'h8: lit = 7'h7F;
		4'h9: lit = 7'h6F;
		4'hA: lit = 7'h77;
		4'hB: lit = 7'h7C;
		4'hC: lit = 7'h39;
		4'hD: lit = 7'h5E;
		4'hE: lit = 7'h79;
		default: lit = 7'h71;
	endcase
	return ~lit;
endfunction

task automatic checkByte(input string name, input byteT got, input byteT expected);
	if (got !== expected) begin
		errorCount++;
		$display("Error: %s is %h, expected %h", name, got, expected);
	end
endtask

task automatic checkSegment(input string name, input segmentT got, input segmentT expected);
	if (got !== expected) begin
		errorCount++;
		$display("Error: %s is %h, expected %h", name, got, expected);
	end
endtask

task automatic checkLeds(input string name, input logic [9:0] got, input logic [9:0] expected);
	if (got !== expected) begin
		errorCount++;
		$display("Error: %s is %h, expected %h", name, got, expected);
	end
endtask

task automatic checkBit(input string name, input logic got, input logic expected);
	if (got !== expected) begin
		errorCount++;
		$display("Error: %s is %h, expected %h", name, got, expected);
	end
endtask

`endif

/* testbench/gameTb.sv */
module gameTb
	import gamePkg::*;
();

	localparam int bitClks = 8;

	logic clk;
	logic reset;
	logic serialIn;
	logic serialOut;
	segmentT hex0;
	segmentT hex1;
	segmentT hex4;
	segmentT hex5;
	logic [9:0] ledr;

	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;
	integer seed = 52;

	`include "gameTbModel.svh"

	gameTop #(.clksPerBit(bitClks)) dut0 (
		.clk(clk),
		.reset(reset),
		.serialIn(serialIn),
		.serialOut(serialOut),
		.hex0(hex0),
		.hex1(hex1),
		.hex4(hex4),
		.hex5(hex5),
		.ledr(ledr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// start bit, data LSB first, then the given stop bit
	task automatic sendFrame(input byteT data, input logic stopBit);
		logic [9:0] frame;
		frame = {stopBit, data, 1'b0};
		@(posedge clk);
		#10;
		for (int i = 0; i < 10; i++) begin
			serialIn = frame[i];
			repeat (bitClks) @(posedge clk);
			#10;
		end
		serialIn = 1'b1;
	endtask

	// waits for a start bit, samples mid-bit, returns after the line is idle
	task automatic receiveByte(input int timeoutCycles, output byteT data, output bit gotIt);
		int waited;
		waited = 0;
		data = '0;
		while (serialOut !== 1'b0 && waited < timeoutCycles) begin
			@(posedge clk);
			#10;
			waited++;
		end
		gotIt = (serialOut === 1'b0);
		if (gotIt) begin
			repeat (bitClks / 2) @(posedge clk);
			#10;
			checkBit("serialOut start bit", serialOut, 1'b0);
			// busy shows on ledr bit 9 while the frame goes out
			checkBit("ledr[9]", ledr[9], 1'b1);
			for (int i = 0; i < 8; i++) begin
				repeat (bitClks) @(posedge clk);
				#10;
				data[i] = serialOut;
			end
			repeat (bitClks) @(posedge clk);
			#10;
			checkBit("serialOut stop bit", serialOut, 1'b1);
			// let busy drop before the LEDs are read
			repeat (bitClks) @(posedge clk);
			#10;
		end
	endtask

	task automatic checkDisplay();
		checkSegment("hex0", hex0, segmentFor({1'b0, modelX}));
		checkSegment("hex1", hex1, segmentFor({2'b00, modelY}));
		checkSegment("hex4", hex4, segmentFor(modelScore[3:0]));
		checkSegment("hex5", hex5, segmentFor({1'b0, modelScore[6:4]}));
		checkLeds("ledr", ledr, {1'b0, modelHit, modelLastReply});
	endtask

	task automatic doCommand(input byteT cmd);
		byteT got;
		byteT expected;
		bit gotIt;
		sendFrame(cmd, 1'b1);
		receiveByte(40 * bitClks, got, gotIt);
		expected = predictReply(cmd);
		modelLastReply = expected;
		if (!gotIt) begin
			errorCount++;
			$display("timeout: no reply to command %h", cmd);
		end else begin
			checkByte("reply", got, expected);
		end
		checkDisplay();
	endtask

	task automatic finishTest(input string name, input int errorsAtStart);
		testCount++;
		if (errorCount == errorsAtStart) begin
			$display("test %s: ok", name);
		end else begin
			failedTests++;
			$display("test %s: %0d errors", name, errorCount - errorsAtStart);
		end
	endtask

	initial begin
		int errorsAtStart;
		logic [4:0] operand;
		byteT got;
		bit gotIt;
		reset = 1'b1;
		serialIn = 1'b1;
		resetModel();
		repeat (10) @(posedge clk);
		#10;
		reset = 1'b0;
		repeat (2) @(posedge clk);
		#10;

		errorsAtStart = errorCount;
		checkBit("serialOut", serialOut, 1'b1);
		checkDisplay();
		doCommand({opResetGame, 5'd0});
		finishTest("after reset", errorsAtStart);

		errorsAtStart = errorCount;
		for (int i = 0; i < 20; i++) begin
			operand = 5'($random(seed));
			doCommand({opMoveAlien, operand});
		end
		finishTest("move alien", errorsAtStart);

		errorsAtStart = errorCount;
		for (int i = 0; i < 20; i++) begin
			operand = 5'($random(seed));
			doCommand({opMoveAlien, operand});
			operand = 5'($random(seed));
			// every other shot aims at the alien to mix hits and misses
			if (i % 2 == 0)
				operand[2:0] = modelX;
			doCommand({opShoot, operand});
		end
		// enough hits to wrap the score past 127
		for (int i = 0; i < 130; i++)
			doCommand({opShoot, 2'b00, modelX});
		finishTest("shoot", errorsAtStart);

		errorsAtStart = errorCount;
		doCommand({opReadScore, 5'd0});
		for (int i = 0; i < 12; i++) begin
			if (i == 6)
				doCommand({opResetGame, 5'd0});
			doCommand({opReadRandom, 5'd0});
		end
		doCommand({opReadScore, 5'd0});
		finishTest("read score and random", errorsAtStart);

		errorsAtStart = errorCount;
		doCommand({opMoveAlien, 5'b10101});
		for (int op = 5; op < 8; op++) begin
			operand = 5'($random(seed));
			doCommand({3'(op), operand});
		end
		finishTest("invalid opcodes", errorsAtStart);

		errorsAtStart = errorCount;
		sendFrame({opReadScore, 5'd0}, 1'b0);
		receiveByte(20 * bitClks, got, gotIt);
		if (gotIt) begin
			errorCount++;
			$display("a frame with a zero stop bit was answered with %h", got);
		end
		checkDisplay();
		doCommand({opShoot, 2'b00, modelX});
		finishTest("bad stop bit", errorsAtStart);

		$display("summary: %0d tests, %0d failed, %0d check errors",
			testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
